/* sim.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_ctrl_if.sv
verilog/rv_control.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_store_unit.sv
verilog/rv_core.sv
tests/tb_clock.sv
tests/rv_core_tb.sv

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps

`include "rv_defines.svh"

module rv_core_tb;

  localparam int NUM_TESTS = 7;
  // no test needs more than 40 cycles with its reset and halt check
  localparam int MAX_CYCLES = 40 * NUM_TESTS;
  localparam int RUN_LIMIT = 40;
  localparam rv_pkg::word_t ECALL = {25'd0, `RV_OP_SYSTEM};
  // reserved custom-2 opcode
  localparam rv_pkg::word_t ILLEGAL = {25'd0, 7'b1011011};

  logic               clk;
  logic               por_rst;
  logic               test_rst;
  logic               rst;
  logic               halt;
  rv_pkg::word_t      insn;
  rv_pkg::word_t      pc;
  rv_pkg::word_t      store_addr;
  rv_pkg::word_t      store_data;
  rv_pkg::byte_mask_t store_we;

  rv_pkg::word_t imem [64];
  rv_pkg::word_t prog [$];
  // store records are {addr, data, mask}
  logic [67:0]   exp_q [$];
  logic [67:0]   obs_q [$];
  rv_pkg::word_t stop_pc;
  logic [31:0]   lfsr;
  int            cycles = 0;
  int            passed;
  int            failed;

  assign rst = por_rst | test_rst;

  tb_clock clock_gen (
    .clk (clk),
    .rst (por_rst)
  );

  rv_core uut (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_we   (store_we),
    .halt       (halt)
  );

  // fetch for the current pc
  always @(negedge clk) begin
    insn <= imem[pc[7:2]];
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // fibonacci lfsr with taps 32 22 2 1, one step per bit
  function automatic rv_pkg::word_t rand_bits(input int n);
    rv_pkg::word_t r;
    logic          fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  // rv32i result of one alu operation
  function automatic rv_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      `RV_F3_ADD:  return alt ? a - b : a + b;
      `RV_F3_SLL:  return a << b[4:0];
      `RV_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `RV_F3_XOR:  return a ^ b;
      `RV_F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      `RV_F3_OR:   return a | b;
      default:     return a & b;
    endcase
  endfunction

  // lui plus addi, with the upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input rv_pkg::word_t value);
    rv_pkg::word_t hi;
    hi = value + 32'h800;
    prog.push_back({hi[31:12], rd, `RV_OP_LUI});
    prog.push_back(enc_i(`RV_OP_IMM, `RV_F3_ADD, rd, rd, value[11:0]));
  endtask

  task automatic store_word(input logic [4:0] rs2, input int slot, input rv_pkg::word_t value);
    prog.push_back(enc_s(`RV_F3_SW, 5'd0, rs2, 12'(slot * 4)));
    exp_q.push_back({rv_pkg::word_t'(slot * 4), value, 4'hf});
  endtask

  task automatic add_stop(input rv_pkg::word_t stop_insn);
    stop_pc = rv_pkg::word_t'(prog.size() * 4);
    prog.push_back(stop_insn);
  endtask

  // unused words get an illegal opcode with the word index above it
  task automatic load_imem();
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {25'(i), 7'h00};
    end
  endtask

  task automatic run_test(input string name);
    int          n;
    int          errs;
    logic [31:0] lanes;
    load_imem();
    obs_q.delete();
    errs = 0;
    n = 0;
    test_rst <= 1'b1;
    @(negedge clk);
    repeat (2) begin
      #40;
      if (pc !== `RV_RESET_PC || store_we !== '0 || halt !== 1'b0) begin
        $display("Fail at time %0t: %s in reset shows pc %h, store_we %b, halt %b",
                 $time, name, pc, store_we, halt);
        errs++;
      end
      @(negedge clk);
    end
    test_rst <= 1'b0;
    do begin
      #40;
      if (n == 0 && (pc !== `RV_RESET_PC || halt !== 1'b0)) begin
        $display("Fail at time %0t: %s starts at pc %h with halt %b", $time, name, pc, halt);
        errs++;
      end
      if (store_we !== '0) begin
        obs_q.push_back({store_addr, store_data, store_we});
      end
      n++;
      @(negedge clk);
    end while (halt !== 1'b1 && n < RUN_LIMIT);
    if (halt !== 1'b1) begin
      $display("%s: the core did not halt within %0d cycles", name, RUN_LIMIT);
      errs++;
    end
    repeat (3) begin
      #40;
      if (pc !== stop_pc || store_we !== '0 || halt !== 1'b1) begin
        $display("Fail at time %0t: %s halted at pc %h with store_we %b, expected pc %h",
                 $time, name, pc, store_we, stop_pc);
        errs++;
      end
      // a store fetched while halted must not reach the port
      imem[stop_pc[7:2]] = enc_s(`RV_F3_SW, 5'd0, 5'd0, 12'h010);
      @(negedge clk);
    end
    if (obs_q.size() != exp_q.size()) begin
      $display("%s: the core made %0d stores where %0d were expected",
               name, obs_q.size(), exp_q.size());
      errs++;
    end
    for (int i = 0; i < obs_q.size() && i < exp_q.size(); i++) begin
      lanes = {{8{exp_q[i][3]}}, {8{exp_q[i][2]}}, {8{exp_q[i][1]}}, {8{exp_q[i][0]}}};
      if (obs_q[i][67:36] !== exp_q[i][67:36] || obs_q[i][3:0] !== exp_q[i][3:0] ||
          (obs_q[i][35:4] & lanes) !== (exp_q[i][35:4] & lanes)) begin
        $display("Fail at time %0t: %s store %0d gave %h %h %b, expected %h %h %b",
                 $time, name, i, obs_q[i][67:36], obs_q[i][35:4], obs_q[i][3:0],
                 exp_q[i][67:36], exp_q[i][35:4], exp_q[i][3:0]);
        errs++;
      end
    end
    if (errs == 0) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, errs);
    end
    prog.delete();
    exp_q.delete();
  endtask

  // funct3 0 to 7 in order, then srai
  task automatic test_imm_arith();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t r;
    logic [11:0]   imm;
    logic [2:0]    f3;
    logic          alt;
    a = rand_bits(32);
    load_const(5'd1, a);
    for (int k = 0; k < 9; k++) begin
      f3 = (k == 8) ? `RV_F3_SR : 3'(k);
      alt = (k == 8);
      if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR) begin
        r = rand_bits(5);
        imm = {(alt ? `RV_F7_ALT : `RV_F7_BASE), r[4:0]};
        b = {27'd0, r[4:0]};
      end else begin
        r = rand_bits(12);
        imm = r[11:0];
        b = {{20{imm[11]}}, imm};
      end
      prog.push_back(enc_i(`RV_OP_IMM, f3, 5'd2, 5'd1, imm));
      store_word(5'd2, k, model_alu(f3, alt, a, b));
    end
    add_stop(ECALL);
    run_test("imm_arith");
  endtask

  // negative rs1 against positive rs2, and large shift amounts
  task automatic test_reg_arith();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    logic [2:0]    f3;
    logic          alt;
    logic          swap;
    a = rand_bits(32) | 32'h8000_0000;
    b = (rand_bits(32) & 32'h7fff_ffff) | 32'h0000_0020;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 12; k++) begin
      f3 = (k < 8) ? 3'(k) : (k == 8) ? `RV_F3_ADD : (k == 9) ? `RV_F3_SR : 3'(k - 8);
      alt = (k == 8 || k == 9);
      swap = (k >= 10);
      prog.push_back(enc_r(alt ? `RV_F7_ALT : `RV_F7_BASE, f3, 5'd3,
                           swap ? 5'd2 : 5'd1, swap ? 5'd1 : 5'd2));
      store_word(5'd3, k, swap ? model_alu(f3, 1'b0, b, a) : model_alu(f3, alt, a, b));
    end
    add_stop(ECALL);
    run_test("reg_arith");
  endtask

  task automatic test_lui();
    rv_pkg::word_t u;
    rv_pkg::word_t c;
    u = rand_bits(20);
    c = rand_bits(32);
    prog.push_back({u[19:0], 5'd3, `RV_OP_LUI});
    store_word(5'd3, 0, {u[19:0], 12'h000});
    load_const(5'd4, c);
    store_word(5'd4, 1, c);
    add_stop(ECALL);
    run_test("lui");
  endtask

  task automatic test_store_lanes();
    rv_pkg::word_t v;
    v = rand_bits(32);
    load_const(5'd1, v);
    for (int k = 0; k < 4; k++) begin
      prog.push_back(enc_s(`RV_F3_SB, 5'd0, 5'd1, 12'(12'h40 + k)));
      exp_q.push_back({32'h40, {24'd0, v[7:0]} << (8 * k), 4'b0001 << k});
    end
    for (int k = 0; k < 2; k++) begin
      prog.push_back(enc_s(`RV_F3_SH, 5'd0, 5'd1, 12'(12'h44 + 2 * k)));
      exp_q.push_back({32'h44, {16'd0, v[15:0]} << (16 * k), 4'b0011 << (2 * k)});
    end
    add_stop(ECALL);
    run_test("store_lanes");
  endtask

  // x1 was loaded by the lane test, so only reset can clear it
  task automatic test_x0();
    store_word(5'd1, 0, 32'd0);
    prog.push_back(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd0, 5'd0, 12'h123));
    prog.push_back({20'habcde, 5'd0, `RV_OP_LUI});
    store_word(5'd0, 1, 32'd0);
    store_word(5'd7, 2, 32'd0);
    add_stop(ECALL);
    run_test("x0_and_reset");
  endtask

  task automatic test_halt(input string name, input rv_pkg::word_t stop_insn);
    rv_pkg::word_t v;
    v = rand_bits(32);
    load_const(5'd1, v);
    store_word(5'd1, 0, v);
    add_stop(stop_insn);
    // never reached
    prog.push_back(enc_s(`RV_F3_SW, 5'd0, 5'd1, 12'h010));
    prog.push_back(enc_s(`RV_F3_SB, 5'd0, 5'd1, 12'h011));
    run_test(name);
  endtask

  initial begin
    lfsr = 32'h39946ba3;
    test_rst = 1'b0;
    insn = ECALL;
    passed = 0;
    failed = 0;
    load_imem();
    wait (por_rst === 1'b0);
    @(negedge clk);
    test_imm_arith();
    test_reg_arith();
    test_lui();
    test_store_lanes();
    test_x0();
    test_halt("halt_ecall", ECALL);
    test_halt("halt_illegal", ILLEGAL);
    $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
    if (failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

// 100 ns clock and a power-on reset of three cycles
module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // released on a falling edge like every other input
  initial begin
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* verilog/rv_alu.sv */
`timescale 1ns/100ps

`include "rv_defines.svh"

module rv_alu (
  rv_ctrl_if.datapath   ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t result
);

  rv_pkg::word_t op_b;
  rv_pkg::word_t addend;
  rv_pkg::word_t sum;
  logic          carry;
  logic          sub_mode;
  logic          lt_signed;
  logic          lt_unsigned;
  logic [$clog2(`RV_XLEN)-1:0] shamt;

  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[$clog2(`RV_XLEN)-1:0];

  // compares share the subtractor
  assign sub_mode = (ctrl.alu_op == rv_pkg::ALU_SUB) ||
                    (ctrl.alu_op == rv_pkg::ALU_SLT) ||
                    (ctrl.alu_op == rv_pkg::ALU_SLTU);

  assign addend = sub_mode ? ~op_b : op_b;
  assign {carry, sum} = {1'b0, rs1_data} + {1'b0, addend} + {{`RV_XLEN{1'b0}}, sub_mode};

  // no carry out of a - b means a < b
  assign lt_unsigned = ~carry;
  // signs differ, so the negative one is smaller
  assign lt_signed = (rs1_data[`RV_XLEN-1] != op_b[`RV_XLEN-1]) ?
                     rs1_data[`RV_XLEN-1] : sum[`RV_XLEN-1];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::ALU_ADD,
      rv_pkg::ALU_SUB:    result = sum;
      rv_pkg::ALU_SLT:    result = rv_pkg::word_t'(lt_signed);
      rv_pkg::ALU_SLTU:   result = rv_pkg::word_t'(lt_unsigned);
      rv_pkg::ALU_XOR:    result = rs1_data ^ op_b;
      rv_pkg::ALU_OR:     result = rs1_data | op_b;
      rv_pkg::ALU_AND:    result = rs1_data & op_b;
      rv_pkg::ALU_SLL:    result = rs1_data << shamt;
      rv_pkg::ALU_SRL:    result = rs1_data >> shamt;
      rv_pkg::ALU_SRA:    result = rv_pkg::word_t'($signed(rs1_data) >>> shamt);
      rv_pkg::ALU_PASS_B: result = op_b;
      default:            result = sum;
    endcase
  end

endmodule

/* verilog/rv_control.sv */
`timescale 1ns/100ps

`include "rv_defines.svh"

module rv_control (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output logic          halt,
  rv_ctrl_if.control    ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  rv_pkg::word_t       imm_i;
  rv_pkg::word_t       imm_s;
  rv_pkg::word_t       imm_u;
  rv_pkg::core_state_e state;
  rv_pkg::word_t       pc_q;

  logic legal;
  logic writes_rd;
  logic is_store;
  logic running;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_u = {insn[31:12], 12'b0};

  assign ctrl.rs1_addr = insn[19:15];
  assign ctrl.rs2_addr = insn[24:20];
  assign ctrl.rd_addr  = insn[11:7];

  always_comb begin
    ctrl.imm        = imm_i;
    ctrl.alu_op     = rv_pkg::ALU_ADD;
    ctrl.use_imm    = 1'b0;
    ctrl.store_size = rv_pkg::SIZE_WORD;
    writes_rd       = 1'b0;
    is_store        = 1'b0;
    legal           = 1'b0;
    case (opcode)
      `RV_OP_LUI: begin
        ctrl.imm     = imm_u;
        ctrl.alu_op  = rv_pkg::ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        writes_rd    = 1'b1;
        legal        = 1'b1;
      end
      `RV_OP_IMM, `RV_OP_REG: begin
        ctrl.use_imm = (opcode == `RV_OP_IMM);
        writes_rd    = 1'b1;
        legal        = (funct7 == `RV_F7_BASE) || (opcode == `RV_OP_IMM);
        case (funct3)
          `RV_F3_ADD: begin
            // funct7 selects sub only in the register form
            if (opcode == `RV_OP_REG && funct7 == `RV_F7_ALT) begin
              ctrl.alu_op = rv_pkg::ALU_SUB;
              legal       = 1'b1;
            end
          end
          `RV_F3_SLL: begin
            ctrl.alu_op = rv_pkg::ALU_SLL;
            legal       = (funct7 == `RV_F7_BASE);
          end
          `RV_F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
          `RV_F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
          `RV_F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
          `RV_F3_SR: begin
            ctrl.alu_op = (funct7 == `RV_F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            legal       = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT);
          end
          `RV_F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
          default:     ctrl.alu_op = rv_pkg::ALU_AND;
        endcase
      end
      `RV_OP_STORE: begin
        ctrl.imm     = imm_s;
        ctrl.use_imm = 1'b1;
        is_store     = 1'b1;
        legal        = 1'b1;
        case (funct3)
          `RV_F3_SB: ctrl.store_size = rv_pkg::SIZE_BYTE;
          `RV_F3_SH: ctrl.store_size = rv_pkg::SIZE_HALF;
          `RV_F3_SW: ctrl.store_size = rv_pkg::SIZE_WORD;
          default:   legal = 1'b0;
        endcase
      end
      // ecall and every other system encoding stop the core
      `RV_OP_SYSTEM: legal = 1'b0;
      default:       legal = 1'b0;
    endcase
  end

  assign running       = (state == rv_pkg::ST_RUN);
  assign ctrl.reg_we   = running && legal && writes_rd;
  // no store leaves the core while reset is held
  assign ctrl.store_en = running && legal && is_store && !rst;

  // pc holds on the stopping instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::ST_RUN;
      pc_q  <= `RV_RESET_PC;
    end else if (running) begin
      if (legal) begin
        pc_q <= pc_q + rv_pkg::word_t'(4);
      end else begin
        state <= rv_pkg::ST_HALTED;
      end
    end
  end

  assign pc   = pc_q;
  assign halt = (state == rv_pkg::ST_HALTED);

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without reset");

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::word_t      insn,
  output rv_pkg::word_t      pc,
  output rv_pkg::word_t      store_addr,
  output rv_pkg::word_t      store_data,
  output rv_pkg::byte_mask_t store_we,
  output logic               halt
);

  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_result;

  rv_ctrl_if ctrl_bus ();

  rv_control u_control (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .pc   (pc),
    .halt (halt),
    .ctrl (ctrl_bus.control)
  );

  // alu result is both the write-back value and the store address
  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl_bus.datapath),
    .rd_data  (alu_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .ctrl     (ctrl_bus.datapath),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  rv_store_unit u_store_unit (
    .ctrl       (ctrl_bus.datapath),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_we   (store_we)
  );

endmodule

/* verilog/rv_ctrl_if.sv */
`timescale 1ns/100ps

// decoded control for the current instruction
interface rv_ctrl_if;

  rv_pkg::reg_addr_t   rs1_addr;
  rv_pkg::reg_addr_t   rs2_addr;
  rv_pkg::reg_addr_t   rd_addr;
  rv_pkg::word_t       imm;
  rv_pkg::alu_op_e     alu_op;
  logic                use_imm;
  logic                reg_we;
  logic                store_en;
  rv_pkg::store_size_e store_size;

  modport control (
    output rs1_addr, rs2_addr, rd_addr, imm, alu_op,
    output use_imm, reg_we, store_en, store_size
  );

  modport datapath (
    input rs1_addr, rs2_addr, rd_addr, imm, alu_op,
    input use_imm, reg_we, store_en, store_size
  );

endinterface

/* verilog/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// architectural sizes
`define RV_XLEN       32
`define RV_NUM_REGS   32
`define RV_RESET_PC   32'h0000_0000

// major opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_STORE   7'b0100011
`define RV_OP_SYSTEM  7'b1110011

// funct3 for alu ops
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct3 for stores
`define RV_F3_SB      3'b000
`define RV_F3_SH      3'b001
`define RV_F3_SW      3'b010

// funct7 variants
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`endif

/* verilog/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

  // data and address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // one enable bit per byte lane
  typedef logic [`RV_XLEN/8-1:0] byte_mask_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } store_size_e;

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } core_state_e;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps

`include "rv_defines.svh"

module rv_regfile (
  input  logic          clk,
  input  logic          rst,
  rv_ctrl_if.datapath   ctrl,
  input  rv_pkg::word_t rd_data,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  assign rs1_data = regs[ctrl.rs1_addr];
  assign rs2_data = regs[ctrl.rs2_addr];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_we && ctrl.rd_addr != '0) begin
      regs[ctrl.rd_addr] <= rd_data;
    end
  end

  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (ctrl.rs1_addr == '0) |-> (rs1_data == '0)
  ) else $error("x0 read back nonzero");

endmodule

/* verilog/rv_store_unit.sv */
`timescale 1ns/100ps

`include "rv_defines.svh"

module rv_store_unit (
  rv_ctrl_if.datapath        ctrl,
  input  rv_pkg::word_t      addr,
  input  rv_pkg::word_t      rs2_data,
  output rv_pkg::word_t      store_addr,
  output rv_pkg::word_t      store_data,
  output rv_pkg::byte_mask_t store_we
);

  rv_pkg::byte_mask_t lane_mask;

  assign store_addr = {addr[`RV_XLEN-1:2], 2'b00};

  // replicate narrow data so every lane carries it
  always_comb begin
    case (ctrl.store_size)
      rv_pkg::SIZE_BYTE: begin
        store_data = {(`RV_XLEN/8){rs2_data[7:0]}};
        lane_mask  = rv_pkg::byte_mask_t'(1) << addr[1:0];
      end
      rv_pkg::SIZE_HALF: begin
        store_data = {(`RV_XLEN/16){rs2_data[15:0]}};
        lane_mask  = rv_pkg::byte_mask_t'(2'b11) << {addr[1], 1'b0};
      end
      default: begin
        store_data = rs2_data;
        lane_mask  = '1;
      end
    endcase
  end

  assign store_we = ctrl.store_en ? lane_mask : '0;

  always_comb begin
    if (ctrl.store_en && ctrl.store_size == rv_pkg::SIZE_HALF) begin
      a_half_aligned: assert final (addr[0] == 1'b0) else $error("misaligned sh");
    end
    if (ctrl.store_en && ctrl.store_size == rv_pkg::SIZE_WORD) begin
      a_word_aligned: assert final (addr[1:0] == 2'b00) else $error("misaligned sw");
    end
  end

endmodule
